//--- sim.f
+incdir+include
hw/qconv_pkg.sv
hw/weight_code_decode.sv
hw/mac_lane.sv
hw/conv_lanes.sv
hw/lane_sum.sv
hw/qconv_axil_regs.sv
hw/qconv_top.sv
bench/qconv_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= qconv_tb
SEED_ARGS ?= +verilator+seed+1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sim.f

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- include/qconv_axil_host.svh
`ifndef QCONV_AXIL_HOST_SVH
`define QCONV_AXIL_HOST_SVH

////////////////////////////////////////////////////////////////////////////
// AXI4-Lite host, DUT outputs sampled on the falling edge
////////////////////////////////////////////////////////////////////////////

task automatic next_cycle(inout int n, input string what);
  @(negedge clk);
  n++;
  assert (n < HS_LIMIT) else fail_now({"Timed out waiting for ", what});
endtask

task automatic drive_write(input logic [7:0] addr, input logic [31:0] data);
  @(negedge clk);
  awaddr  = addr;
  wdata   = data;
  wstrb   = 4'hf;
  awvalid = 1'b1;
  wvalid  = 1'b1;
endtask

task automatic await_write_accept();
  int n = 0;
  while (!awready) next_cycle(n, "awready"); // Taken on the next rising edge.
  expect_eq("wready", 32'h1, 32'(wready));
  @(negedge clk);
  awvalid = 1'b0;
  wvalid  = 1'b0;
endtask

task automatic take_write_resp();
  int n = 0;
  bready = 1'b1;
  while (!bvalid) next_cycle(n, "bvalid");
  expect_eq("BRESP", 32'h0, 32'(bresp));
  @(negedge clk);
  bready = 1'b0;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
  drive_write(addr, data);
  await_write_accept();
  take_write_resp();
endtask

task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
  int n = 0;
  @(negedge clk);
  araddr  = addr;
  arvalid = 1'b1;
  while (!arready) next_cycle(n, "arready");
  @(negedge clk);
  arvalid = 1'b0;
  rready  = 1'b1;
  n = 0;
  while (!rvalid) next_cycle(n, "rvalid");
  data = rdata;
  resp = rresp;
  @(negedge clk);
  rready = 1'b0;
endtask

`endif

//--- bench/qconv_tb.sv
`timescale 1ns/1ps

module qconv_tb;
  import qconv_pkg::*;

  localparam int LANES    = 4;
  localparam int HS_LIMIT = 40; // Cycles per handshake, polls per idle wait.

  logic        clk     = 1'b0;
  logic        rst     = 1'b0;
  logic [7:0]  awaddr  = '0;
  logic        awvalid = 1'b0;
  logic [31:0] wdata   = '0;
  logic [3:0]  wstrb   = '0;
  logic        wvalid  = 1'b0;
  logic        bready  = 1'b0;
  logic [7:0]  araddr  = '0;
  logic        arvalid = 1'b0;
  logic        rready  = 1'b0;
  logic        awready;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;

  int          errors      = 0;
  int          step_count  = 0;
  int          model_acc [LANES];
  logic [31:0] cur_weights = '0;
  logic [7:0]  cur_codes   = '0;
  logic        cur_en      = 1'b0;
  logic [31:0] expected    = '0;
  string       chk_name_q [$];
  logic [31:0] chk_exp_q [$];
  logic [31:0] chk_act_q [$];

  qconv_top #(.LANES(LANES)) dut (
    .clk, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  always #10 clk = ~clk;

  task automatic fail_now(input string what);
    errors++;
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_name_q.push_back(name);
    chk_exp_q.push_back(exp);
    chk_act_q.push_back(act);
  endtask

  `include "qconv_axil_host.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // 3 positive, 1 first negative, 0 second negative, 2 zero.
  function automatic int code_weight(input logic [1:0] code, input logic [31:0] wreg);
    logic signed [7:0] w;
    case (code)
      2'd3:    w = wreg[7:0];
      2'd1:    w = wreg[15:8];
      2'd0:    w = wreg[23:16];
      default: w = '0;
    endcase
    return int'(w);
  endfunction

  function automatic logic [31:0] predict_step(input logic [31:0] data);
    int total = 0;
    for (int i = 0; i < LANES; i++) begin
      if (cur_en) begin
        model_acc[i] += int'(data[8*(LANES-1-i) +: 8]) * // Lane 0 on top byte.
                        code_weight(cur_codes[2*(LANES-1-i) +: 2], cur_weights);
      end
      total += model_acc[i];
    end
    return total;
  endfunction

  always @(negedge clk) begin
    string       name;
    logic [31:0] exp_v;
    logic [31:0] act_v;
    while (chk_act_q.size() > 0) begin
      name  = chk_name_q.pop_front();
      exp_v = chk_exp_q.pop_front();
      act_v = chk_act_q.pop_front();
      assert (act_v === exp_v) else
        fail_now($sformatf("Mismatch %s expected %08h actual %08h", name, exp_v, act_v));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register level steps
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_idle();
    logic [31:0] status = 32'h1;
    logic [1:0]  resp;
    int          n = 0;
    while (status[0]) begin
      read_reg(REG_STATUS, status, resp);
      n++;
      assert (n < HS_LIMIT) else fail_now("Busy did not clear in STATUS");
    end
  endtask

  task automatic check_reg(input logic [7:0] addr, input string name, input logic [31:0] exp);
    logic [31:0] val;
    logic [1:0]  resp;
    read_reg(addr, val, resp);
    expect_eq("RRESP", 32'h0, 32'(resp));
    expect_eq(name, exp, val);
  endtask

  task automatic set_ctrl(input logic [31:0] val);
    write_reg(REG_CTRL, val);
    cur_en = val[0];
    if (val[1]) begin
      model_acc  = '{default: 0};
      step_count = 0;
      expected   = '0;
    end
    wait_idle();
  endtask

  task automatic load_lanes(input logic [31:0] weights, input logic [31:0] codes);
    write_reg(REG_WEIGHTS, weights);
    write_reg(REG_CODES, codes);
    cur_weights = weights;
    cur_codes   = codes[7:0];
  endtask

  task automatic run_step(input logic [31:0] data);
    write_reg(REG_DATA, data);
    expected = predict_step(data);
    step_count++;
    wait_idle();
    check_reg(REG_RESULT, "RESULT", expected);
  endtask

  initial begin
    logic [31:0] rd_val;
    logic [1:0]  rd_resp;
    int          n;
    void'($urandom(32'hf7ef));
    repeat (8) @(negedge clk);
    rst = 1'b1;

    check_reg(REG_RESULT, "RESULT", 32'h0);
    check_reg(REG_STATUS, "STATUS", 32'h0);
    read_reg(8'h18, rd_val, rd_resp); // Unmapped.
    expect_eq("RRESP", 32'h2, 32'(rd_resp));

    for (int c = 0; c < 4; c++) begin
      set_ctrl(32'h3);
      load_lanes(32'h0085_f335, 32'({LANES{2'(c)}}));
      run_step($urandom());
    end

    set_ctrl(32'h3);
    for (int s = 0; s < 40; s++) begin
      load_lanes($urandom(), $urandom());
      run_step($urandom());
    end
    check_reg(REG_STATUS, "STATUS", {16'(step_count), 16'h0});

    set_ctrl(32'h0); // Enable low.
    load_lanes(32'h0085_f335, 32'h0000_00ff);
    run_step(32'hffff_ffff);
    run_step($urandom() | 32'h1);

    set_ctrl(32'h3);
    check_reg(REG_RESULT, "RESULT", 32'h0);
    check_reg(REG_STATUS, "STATUS", 32'h0);
    run_step($urandom());

    // Second write waits behind an unanswered response.
    drive_write(REG_DATA, 32'h1020_30ff);
    await_write_accept();
    expected = predict_step(32'h1020_30ff);
    drive_write(REG_DATA, 32'hc0de_0a55);
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      expect_eq("awready", 32'h0, 32'(awready));
      expect_eq("wready", 32'h0, 32'(wready));
      expect_eq("bvalid", 32'h1, 32'(bvalid));
    end
    take_write_resp();
    await_write_accept();
    expected = predict_step(32'hc0de_0a55);
    take_write_resp();
    step_count += 2;
    wait_idle();
    check_reg(REG_RESULT, "RESULT", expected);
    check_reg(REG_STATUS, "STATUS", {16'(step_count), 16'h0});

    n = 0;
    while (chk_act_q.size() > 0) begin
      @(negedge clk);
      n++;
      assert (n < HS_LIMIT) else fail_now("Compare queue did not drain");
    end
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- hw/qconv_top.sv
`timescale 1ns/1ps

module qconv_top #(
  parameter int LANES = 4
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [qconv_pkg::AXIL_ADDR_W-1:0]    awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [qconv_pkg::AXIL_DATA_W-1:0]    wdata,
  input  logic [qconv_pkg::AXIL_DATA_W/8-1:0]  wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [qconv_pkg::AXIL_ADDR_W-1:0]    araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [qconv_pkg::AXIL_DATA_W-1:0]    rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready
);
  import qconv_pkg::*;

  weight_set_t                   weights;
  step_cmd_t                     cmd;
  logic [LANES-1:0][WGT_W-1:0]   lane_weights;
  logic [LANES-1:0][ACC_W-1:0]   lane_acc;
  logic                          done;
  logic [ACC_W-1:0]              result;
  logic                          result_valid;

  qconv_axil_regs #(.LANES(LANES)) u_regs (
    .clk, .rst,
    .awaddr, .awvalid, .awready,
    .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .result, .result_valid,
    .weights, .cmd
  );

  // Decode.
  weight_code_decode #(.LANES(LANES)) u_decode (
    .weights      (weights),
    .codes        (cmd.codes[2*LANES-1:0]),
    .enable       (cmd.enable),
    .lane_weights (lane_weights)
  );

  // Execute.
  conv_lanes #(.LANES(LANES)) u_lanes (
    .clk, .rst,
    .cmd, .lane_weights,
    .lane_acc, .done
  );

  // Result.
  lane_sum #(.LANES(LANES)) u_sum (
    .clk, .rst,
    .lane_acc, .done,
    .result, .result_valid
  );

endmodule

//--- hw/qconv_axil_regs.sv
`timescale 1ns/1ps

module qconv_axil_regs #(
  parameter int LANES = 4
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [qconv_pkg::AXIL_ADDR_W-1:0]    awaddr,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [qconv_pkg::AXIL_DATA_W-1:0]    wdata,
  input  logic [qconv_pkg::AXIL_DATA_W/8-1:0]  wstrb,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [qconv_pkg::AXIL_ADDR_W-1:0]    araddr,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [qconv_pkg::AXIL_DATA_W-1:0]    rdata,
  output logic [1:0]                           rresp,
  output logic                                 rvalid,
  input  logic                                 rready,
  input  logic [qconv_pkg::ACC_W-1:0]          result,
  input  logic                                 result_valid,
  output qconv_pkg::weight_set_t               weights,
  output qconv_pkg::step_cmd_t                 cmd
);
  import qconv_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                   wr_fire;
  logic                   rd_fire;
  logic                   issue_step;
  logic                   issue_clear;
  logic                   ctrl_en;
  logic [2*LANES-1:0]     codes_q;
  logic [ACC_W-1:0]       result_q;
  logic [2:0]             inflight;
  logic [STEP_CNT_W-1:0]  step_cnt;
  logic                   busy;
  logic [AXIL_DATA_W-1:0] ctrl_wr;
  logic [AXIL_DATA_W-1:0] weights_wr;
  logic [AXIL_DATA_W-1:0] codes_wr;
  logic [AXIL_DATA_W-1:0] rd_mux;

  function automatic logic [AXIL_DATA_W-1:0] apply_strb(
    input logic [AXIL_DATA_W-1:0]   old_val,
    input logic [AXIL_DATA_W-1:0]   new_val,
    input logic [AXIL_DATA_W/8-1:0] strb
  );
    logic [AXIL_DATA_W-1:0] res;
    res = old_val;
    for (int b = 0; b < AXIL_DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic is_mapped(input logic [AXIL_ADDR_W-1:0] addr);
    return addr inside {REG_CTRL, REG_WEIGHTS, REG_CODES, REG_DATA, REG_RESULT, REG_STATUS};
  endfunction

  assign wr_fire = awready && awvalid && wvalid;
  assign rd_fire = arready && arvalid;

  assign ctrl_wr    = apply_strb(AXIL_DATA_W'(ctrl_en), wdata, wstrb);
  assign weights_wr = apply_strb(AXIL_DATA_W'(weights), wdata, wstrb);
  assign codes_wr   = apply_strb(AXIL_DATA_W'(codes_q), wdata, wstrb);

  assign issue_step  = wr_fire && (awaddr == REG_DATA);
  assign issue_clear = wr_fire && (awaddr == REG_CTRL) && ctrl_wr[CTRL_CLR_BIT];

  // Last in-flight command retiring this cycle.
  assign busy = (inflight - {2'b00, result_valid}) != 3'd0;

  ////////////////////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= awvalid && wvalid && !awready && !bvalid; // AW and W together.
      wready  <= awvalid && wvalid && !awready && !bvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file and command issue
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ctrl_en  <= 1'b0;
      weights  <= '0;
      codes_q  <= '0;
      cmd      <= '0;
      step_cnt <= '0;
      inflight <= '0;
      result_q <= '0;
    end else begin
      cmd.valid <= 1'b0; // Single cycle pulse.
      if (wr_fire && awaddr == REG_CTRL) begin
        ctrl_en <= ctrl_wr[CTRL_EN_BIT];
      end
      if (wr_fire && awaddr == REG_WEIGHTS) begin
        weights <= weights_wr[$bits(weight_set_t)-1:0];
      end
      if (wr_fire && awaddr == REG_CODES) begin
        codes_q <= codes_wr[2*LANES-1:0];
      end
      if (issue_step) begin
        cmd.valid  <= 1'b1;
        cmd.clear  <= 1'b0;
        cmd.enable <= ctrl_en;
        cmd.data   <= wdata;
        cmd.codes  <= CODES_W'(codes_q);
        step_cnt   <= step_cnt + 1'b1;
      end else if (issue_clear) begin
        cmd.valid  <= 1'b1;
        cmd.clear  <= 1'b1;
        cmd.enable <= ctrl_wr[CTRL_EN_BIT];
        step_cnt   <= '0;
      end
      inflight <= inflight + {2'b00, issue_step || issue_clear} - {2'b00, result_valid};
      if (result_valid) begin
        result_q <= result;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (araddr)
      REG_CTRL:    rd_mux[CTRL_EN_BIT] = ctrl_en;
      REG_WEIGHTS: rd_mux = AXIL_DATA_W'(weights);
      REG_CODES:   rd_mux = AXIL_DATA_W'(codes_q);
      REG_DATA:    rd_mux = cmd.data; // Last data word.
      REG_RESULT:  rd_mux = result_valid ? result : result_q;
      REG_STATUS:  rd_mux = {step_cnt, {(AXIL_DATA_W-STEP_CNT_W-1){1'b0}}, busy};
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_mux;
      rresp <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  a_aw_with_w: assert property (@(posedge clk) disable iff (!rst)
    (wready && wvalid) |-> awvalid);

  // Response held and unchanged until taken.
  a_b_hold: assert property (@(posedge clk) disable iff (!rst)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)));

endmodule

//--- hw/lane_sum.sv
`timescale 1ns/1ps

module lane_sum #(
  parameter int LANES = 4
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [LANES-1:0][qconv_pkg::ACC_W-1:0] lane_acc,
  input  logic                                   done,
  output logic [qconv_pkg::ACC_W-1:0]            result,
  output logic                                   result_valid
);
  import qconv_pkg::*;

  logic signed [ACC_W-1:0] sum;

  always_comb begin
    sum = '0;
    for (int i = 0; i < LANES; i++) begin
      sum = sum + $signed(lane_acc[i]); // Wraps at ACC_W.
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= done;
      if (done) begin
        result <= sum;
      end
    end
  end

endmodule

//--- hw/conv_lanes.sv
`timescale 1ns/1ps

module conv_lanes #(
  parameter int LANES = 4
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  qconv_pkg::step_cmd_t                   cmd,
  input  logic [LANES-1:0][qconv_pkg::WGT_W-1:0] lane_weights,
  output logic [LANES-1:0][qconv_pkg::ACC_W-1:0] lane_acc,
  output logic                                   done
);
  import qconv_pkg::*;

  logic [PIX_W*LANES-1:0] pix_word;
  logic                   lane_step;
  logic                   lane_clear;

  // Disabled steps add zero.
  assign pix_word = cmd.enable ? cmd.data[PIX_W*LANES-1:0] : '0;

  assign lane_step  = cmd.valid && !cmd.clear;
  assign lane_clear = cmd.valid && cmd.clear;

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    mac_lane u_mac (
      .clk    (clk),
      .rst    (rst),
      .pixel  (pix_word[PIX_W*(LANES-1-i) +: PIX_W]), // Lane 0 on top byte.
      .weight (lane_weights[i]),
      .step   (lane_step),
      .clear  (lane_clear),
      .acc    (lane_acc[i])
    );
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      done <= 1'b0;
    end else begin
      done <= cmd.valid;
    end
  end

endmodule

//--- hw/mac_lane.sv
`timescale 1ns/1ps

module mac_lane (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [qconv_pkg::PIX_W-1:0]         pixel,
  input  logic signed [qconv_pkg::WGT_W-1:0]  weight,
  input  logic                                step,
  input  logic                                clear,
  output logic signed [qconv_pkg::ACC_W-1:0]  acc
);
  import qconv_pkg::*;

  logic signed [PIX_W+WGT_W:0] prod;
  logic signed [ACC_W-1:0]     prod_ext;

  assign prod     = $signed({1'b0, pixel}) * weight; // Pixel is unsigned.
  assign prod_ext = ACC_W'(prod);

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      acc <= '0;
    end else if (clear) begin
      acc <= '0;
    end else if (step) begin
      acc <= acc + prod_ext; // Wraps at ACC_W.
    end
  end

  a_step_clear_excl: assert property (@(posedge clk) disable iff (!rst)
    !(step && clear));

endmodule

//--- hw/weight_code_decode.sv
`timescale 1ns/1ps

module weight_code_decode #(
  parameter int LANES = 4
) (
  input  qconv_pkg::weight_set_t                   weights,
  input  logic [2*LANES-1:0]                       codes,
  input  logic                                     enable,
  output logic [LANES-1:0][qconv_pkg::WGT_W-1:0]   lane_weights
);
  import qconv_pkg::*;

  always_comb begin
    lane_weights = '0;
    if (enable) begin
      for (int i = 0; i < LANES; i++) begin
        // Lane 0 takes the top code pair.
        case (codes[2*(LANES-1-i) +: 2])
          CODE_POS:  lane_weights[i] = weights.pos;
          CODE_NEG1: lane_weights[i] = weights.neg1;
          CODE_NEG2: lane_weights[i] = weights.neg2;
          CODE_ZERO: lane_weights[i] = '0;
        endcase
      end
    end
  end

endmodule

//--- hw/qconv_pkg.sv
package qconv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and datapath widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;

  localparam int PIX_W      = 8;
  localparam int WGT_W      = 8;
  localparam int ACC_W      = 32;
  localparam int MAX_LANES  = 4;
  localparam int CODES_W    = 2 * MAX_LANES;
  localparam int STEP_CNT_W = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [AXIL_ADDR_W-1:0] REG_CTRL    = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] REG_WEIGHTS = 8'h04;
  localparam logic [AXIL_ADDR_W-1:0] REG_CODES   = 8'h08; // Lane 0 in top pair.
  localparam logic [AXIL_ADDR_W-1:0] REG_DATA    = 8'h0C; // Write starts a step.
  localparam logic [AXIL_ADDR_W-1:0] REG_RESULT  = 8'h10; // Read only.
  localparam logic [AXIL_ADDR_W-1:0] REG_STATUS  = 8'h14; // Read only.

  localparam int CTRL_EN_BIT  = 0;
  localparam int CTRL_CLR_BIT = 1; // Self clearing.

  ////////////////////////////////////////////////////////////////////////////
  // Weight codes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [1:0] CODE_NEG2 = 2'd0;
  localparam logic [1:0] CODE_NEG1 = 2'd1;
  localparam logic [1:0] CODE_ZERO = 2'd2;
  localparam logic [1:0] CODE_POS  = 2'd3;

  // Packed order matches WEIGHTS bits 23:0.
  typedef struct packed {
    logic signed [WGT_W-1:0] neg2;
    logic signed [WGT_W-1:0] neg1;
    logic signed [WGT_W-1:0] pos;
  } weight_set_t;

  // One command into the datapath.
  typedef struct packed {
    logic                   valid;
    logic                   clear;
    logic                   enable;
    logic [AXIL_DATA_W-1:0] data;
    logic [CODES_W-1:0]     codes;
  } step_cmd_t;

endpackage
